//--- dv/sdram_model.sv
module sdram_model (
    input  logic        clk_sys,
    input  logic        reset_n,
    input  logic        slow,       // Force the longest ready latency
    input  logic [24:0] sdr_addr,
    input  logic [15:0] sdr_din,
    input  logic [1:0]  sdr_wr_sel,
    input  logic        sdr_req,
    output logic [15:0] sdr_dout,
    output logic        sdr_rdy
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0] ram [64];  // Work RAM window at 0x300000
    logic [24:0] addr_q;
    logic [15:0] din_q;
    logic [1:0]  sel_q;
    int          wait_cnt;
    integer      seed;

    initial begin
        seed     = 32'hf473_3ea8;
        sdr_dout = '0;
        sdr_rdy  = 1'b0;
        wait_cnt = 0;
        for (int i = 0; i < 64; i++) ram[6'(i)] = 16'(i * 16'h0101) ^ 16'h3c3c;
    end

    // Outputs change 1 ns after the edge, like the rest of the stimulus
    always @(posedge clk_sys) begin
        #1;
        sdr_rdy = 1'b0;
        if (!reset_n) begin
            wait_cnt = 0;
        end else if (sdr_req) begin
            addr_q   = sdr_addr;
            din_q    = sdr_din;
            sel_q    = sdr_wr_sel;
            wait_cnt = slow ? 6 : 1 + int'($unsigned($random(seed)) % 6);
        end else if (wait_cnt > 0) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
                if (sel_q == 2'b00) begin
                    sdr_dout = (addr_q >= 25'h300000) ? ram[addr_q[6:1]]
                                                      : addr_q[15:0] ^ 16'h5a5a;
                end
                if (sel_q[1]) ram[addr_q[6:1]][15:8] = din_q[15:8];
                if (sel_q[0]) ram[addr_q[6:1]][7:0] = din_q[7:0];
                sdr_rdy = 1'b1;
            end
        end
    end

endmodule

//--- dv/tb_cpu_sdram_bridge.sv
module tb_cpu_sdram_bridge;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk_sys;
    logic        reset_n;
    logic        bus_read;
    logic        bus_write;
    logic [1:0]  bus_be;
    logic [19:0] bus_addr;
    logic [15:0] bus_datawrite;
    logic [15:0] bus_dataread;
    logic        bus_stall;
    logic [3:0]  bank_select;
    logic [24:0] sdr_addr;
    logic [15:0] sdr_din;
    logic [1:0]  sdr_wr_sel;
    logic        sdr_req;
    logic [15:0] sdr_dout;
    logic        sdr_rdy;
    logic        slow_rdy;

    // Expected SDRAM requests in issue order
    logic [24:0] exp_addr [64];
    logic [15:0] exp_din  [64];
    logic [1:0]  exp_sel  [64];
    logic [5:0]  exp_wr = '0;
    logic [5:0]  exp_rd = '0;
    logic        req_seen = 1'b0;

    string test_name = "reset";
    int    check_errors = 0;
    int    req_errors = 0;
    int    err_base;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    cycles = 0;
    logic  stall_seen;

    cpu_sdram_bridge #(.QUEUE_DEPTH(4)) dut (.*);
    sdram_model u_sdram (.*, .slow(slow_rdy));

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ========================================================================
    // Request checking
    // ========================================================================
    always @(negedge clk_sys) begin
        if (req_seen) exp_rd = exp_rd + 6'd1;  // Advance only after the check edge
        req_seen = sdr_req;
    end

    a_req_matches: assert property (@(posedge clk_sys) disable iff (!reset_n)
        sdr_req |-> exp_rd != exp_wr && sdr_addr == exp_addr[exp_rd]
                    && sdr_wr_sel == exp_sel[exp_rd]
                    && (exp_sel[exp_rd] == 2'b00 || sdr_din == exp_din[exp_rd]))
    else begin
        if (exp_rd == exp_wr)
            $display("Failure in %s: sdr_req issued with no request expected", test_name);
        else
            $display("** Error [%s] sdr_req: expected %h/%h/%b, actual %h/%h/%b", test_name,
                     exp_addr[exp_rd], exp_din[exp_rd], exp_sel[exp_rd],
                     sdr_addr, sdr_din, sdr_wr_sel);
        req_errors++;
    end

    // ========================================================================
    // Reference rules and stimulus
    // ========================================================================
    function automatic logic [24:0] sdram_addr_of(input logic [19:0] a, input logic [3:0] bank);
        logic [24:0] off;
        off = (a <= 20'h9ffff) ? {5'd0, a} :
              (a <= 20'hbffff) ? 25'(a - 20'ha0000) : 25'(a - 20'he0000);
        off[0] = 1'b0;
        if (a <= 20'h9ffff) return off;
        if (a <= 20'hbffff) return 25'h100000 + 25'(bank) * 25'h20000 + off;
        return 25'h300000 + off;
    endfunction

    function automatic logic [15:0] rom_read_value(input logic [19:0] a, input logic [3:0] bank);
        logic [15:0] w;
        w = 16'(sdram_addr_of(a, bank)) ^ 16'h5a5a;
        return a[0] ? {8'h00, w[15:8]} : w;
    endfunction

    task automatic step();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic expect_req(input logic [24:0] a, input logic [15:0] d, input logic [1:0] sel);
        exp_addr[exp_wr] = a;
        exp_din[exp_wr]  = d;
        exp_sel[exp_wr]  = sel;
        exp_wr           = exp_wr + 6'd1;
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp) else begin
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
            check_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("Failure in %s: %s", test_name, msg);
            check_errors++;
        end
    endtask

    task automatic cpu_read(input logic [19:0] a, input logic [15:0] exp_data);
        expect_req(sdram_addr_of(a, bank_select), 16'h0000, 2'b00);
        while (bus_stall) step();
        bus_read      = 1'b1;
        bus_addr      = a;
        bus_be        = 2'b11;
        bus_datawrite = 16'h0000;
        step();
        bus_read = 1'b0;
        check_true(bus_stall, "bus_stall did not rise after the read strobe");
        while (bus_stall) step();  // Falls with the data latched
        check_value("bus_dataread", 32'(exp_data), 32'(bus_dataread));
    endtask

    task automatic cpu_write(input logic [19:0] a, input logic [1:0] be, input logic [15:0] d,
                             input logic to_sdram);
        if (to_sdram) begin
            expect_req(sdram_addr_of(a, bank_select), a[0] ? 16'(d << 8) : d,
                       a[0] ? 2'(be << 1) : be);
        end
        if (bus_stall) stall_seen = 1'b1;
        while (bus_stall) step();
        bus_write     = 1'b1;
        bus_addr      = a;
        bus_be        = be;
        bus_datawrite = d;
        step();
        bus_write = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_base  = check_errors + req_errors;
    endtask

    task automatic end_test();
        int n;
        while (exp_rd != exp_wr) step();  // Every queued request reached the port
        n = check_errors + req_errors - err_base;
        if (n == 0) begin
            tests_passed++;
            $display("PASS  %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", test_name, n);
        end
    endtask

    initial begin
        reset_n       = 1'b0;
        bus_read      = 1'b0;
        bus_write     = 1'b0;
        bus_be        = 2'b00;
        bus_addr      = '0;
        bus_datawrite = '0;
        bank_select   = '0;
        slow_rdy      = 1'b0;
        stall_seen    = 1'b0;
        repeat (5) @(posedge clk_sys);
        #1;
        reset_n = 1'b1;
        step();

        start_test("aligned ROM read");
        cpu_read(20'h01234, rom_read_value(20'h01234, 4'd0));
        cpu_read(20'h9fffe, rom_read_value(20'h9fffe, 4'd0));
        end_test();

        start_test("odd ROM read");
        cpu_read(20'h04567, rom_read_value(20'h04567, 4'd0));
        end_test();

        start_test("banked ROM read");
        bank_select = 4'd0;
        cpu_read(20'ha0004, rom_read_value(20'ha0004, 4'd0));
        bank_select = 4'd5;
        cpu_read(20'ha1235, rom_read_value(20'ha1235, 4'd5));
        bank_select = 4'd15;
        cpu_read(20'hbfffe, rom_read_value(20'hbfffe, 4'd15));
        end_test();

        start_test("RAM writes and read back");
        cpu_write(20'he0010, 2'b11, 16'h1234, 1'b1);
        cpu_write(20'he0011, 2'b01, 16'h00ab, 1'b1);  // Lands on the upper lane
        cpu_read(20'he0010, 16'hab34);
        cpu_read(20'he0011, 16'h00ab);
        end_test();

        start_test("write to ROM dropped");
        cpu_write(20'h02000, 2'b11, 16'hdead, 1'b0);
        repeat (20) begin
            check_true(!bus_stall, "bus_stall rose after a write to ROM");
            step();
        end
        end_test();

        start_test("RAM write burst under slow ready");
        slow_rdy   = 1'b1;
        stall_seen = 1'b0;
        for (int i = 0; i < 8; i++) begin
            cpu_write(20'he0020 + 20'(2 * i), 2'b11, 16'hc0de ^ 16'(i * 16'h1111), 1'b1);
        end
        cpu_read(20'he002e, 16'hc0de ^ 16'h7777);
        check_true(stall_seen, "bus_stall never rose while the queue was full");
        slow_rdy = 1'b0;
        end_test();

        $display("Summary: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 check_errors + req_errors);
        if (tests_failed == 0 && check_errors + req_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/cpu_bus_capture.sv
module cpu_bus_capture import cpu_bus_pkg::*; (
    input  logic      clk_sys,
    input  logic      reset_n,

    input  logic      bus_read,
    input  logic      bus_write,
    input  byte_sel_t bus_be,
    input  cpu_addr_t bus_addr,
    input  word_t     bus_datawrite,
    input  bank_t     bank_select,
    output word_t     bus_dataread,
    output logic      bus_stall,

    output logic      push,
    output req_word_t push_data,
    input  logic      full,

    input  logic      read_done,
    input  word_t     rd_word
);

    logic      in_rom, in_bank, in_ram, mapped;
    cpu_addr_t bank_off, ram_off;
    sdr_addr_t req_addr;
    word_t     req_data;
    byte_sel_t req_sel;
    logic      rd_pending;

    // Region decode
    assign in_rom  = bus_addr <= ROM_LIMIT;
    assign in_bank = bus_addr >= BANK_BASE && bus_addr <= BANK_LIMIT;
    assign in_ram  = bus_addr >= RAM_BASE && bus_addr <= RAM_LIMIT;
    assign mapped  = in_rom | in_bank | in_ram;

    assign bank_off = bus_addr - BANK_BASE;
    assign ram_off  = bus_addr - RAM_BASE;

    always_comb begin
        if (in_bank) begin
            req_addr = SDR_BANK_BASE + sdr_addr_t'({bank_select, {BANK_SHIFT{1'b0}}})
                     + sdr_addr_t'({bank_off[19:1], 1'b0});
        end else if (in_ram) begin
            req_addr = SDR_RAM_BASE + sdr_addr_t'({ram_off[19:1], 1'b0});
        end else begin
            req_addr = sdr_addr_t'({bus_addr[19:1], 1'b0});  // ROM maps 1:1
        end
    end

    // Odd byte writes go out on the upper lane
    assign req_data = bus_addr[0] ? {bus_datawrite[7:0], 8'h00} : bus_datawrite;
    assign req_sel  = bus_write ? (bus_addr[0] ? {bus_be[0], 1'b0} : bus_be) : 2'b00;

    // Writes only land in RAM, ROM writes vanish here
    assign push = (bus_read & mapped) | (bus_write & in_ram);

    always_comb begin
        push_data = '0;
        push_data[REQ_ADDR_LSB +: $bits(sdr_addr_t)] = req_addr;
        push_data[REQ_DATA_LSB +: $bits(word_t)]     = req_data;
        push_data[REQ_SEL_LSB +: $bits(byte_sel_t)]  = req_sel;
        push_data[REQ_ODD_BIT]                       = bus_addr[0];
    end

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            rd_pending <= 1'b0;
        end else if (read_done) begin
            rd_pending <= 1'b0;
        end else if (bus_read && mapped) begin
            rd_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (read_done) bus_dataread <= rd_word;
    end

    assign bus_stall = rd_pending | full;  // Hold CPU off a full queue too

    // CPU must wait out the stall, whether from a read or a full queue
    a_no_strobe_in_stall: assert property (@(posedge clk_sys) disable iff (!reset_n)
        bus_stall |-> !(bus_read || bus_write));

    // A finished read always belongs to the read the CPU is waiting on
    a_done_when_pending: assert property (@(posedge clk_sys) disable iff (!reset_n)
        read_done |-> rd_pending);

endmodule

//--- rtl/cpu_bus_pkg.sv
package cpu_bus_pkg;

    // ========================================================================
    // Bus and SDRAM widths
    // ========================================================================
    typedef logic [19:0] cpu_addr_t;  // CPU byte address
    typedef logic [24:0] sdr_addr_t;
    typedef logic [15:0] word_t;
    typedef logic [1:0]  byte_sel_t;  // Bit 1 is upper lane, zero means read
    typedef logic [3:0]  bank_t;

    // ========================================================================
    // Memory map
    // ========================================================================
    localparam cpu_addr_t ROM_LIMIT  = 20'h9ffff;
    localparam cpu_addr_t BANK_BASE  = 20'ha0000;
    localparam cpu_addr_t BANK_LIMIT = 20'hbffff;
    localparam cpu_addr_t RAM_BASE   = 20'he0000;
    localparam cpu_addr_t RAM_LIMIT  = 20'heffff;

    localparam sdr_addr_t SDR_BANK_BASE = 25'h100000;
    localparam sdr_addr_t SDR_RAM_BASE  = 25'h300000;
    localparam int        BANK_SHIFT    = 17;  // Each bank is 0x20000 bytes

    // ========================================================================
    // Request word layout, low to high
    // ========================================================================
    localparam int REQ_ODD_BIT  = 0;
    localparam int REQ_SEL_LSB  = REQ_ODD_BIT + 1;
    localparam int REQ_DATA_LSB = REQ_SEL_LSB + $bits(byte_sel_t);
    localparam int REQ_ADDR_LSB = REQ_DATA_LSB + $bits(word_t);
    localparam int REQ_W        = REQ_ADDR_LSB + $bits(sdr_addr_t);  // 44

    typedef logic [REQ_W-1:0] req_word_t;

endpackage

//--- rtl/cpu_sdram_bridge.sv
module cpu_sdram_bridge import cpu_bus_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic      clk_sys,
    input  logic      reset_n,

    // CPU bus
    input  logic      bus_read,
    input  logic      bus_write,
    input  byte_sel_t bus_be,
    input  cpu_addr_t bus_addr,
    input  word_t     bus_datawrite,
    output word_t     bus_dataread,
    output logic      bus_stall,
    input  bank_t     bank_select,

    // SDRAM port
    output sdr_addr_t sdr_addr,
    output word_t     sdr_din,
    output byte_sel_t sdr_wr_sel,
    output logic      sdr_req,
    input  word_t     sdr_dout,
    input  logic      sdr_rdy
);

    logic      push, pop, full, empty;
    req_word_t push_data, head_data;
    logic      read_done;
    word_t     rd_word;

    cpu_bus_capture u_capture (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .bus_read      (bus_read),
        .bus_write     (bus_write),
        .bus_be        (bus_be),
        .bus_addr      (bus_addr),
        .bus_datawrite (bus_datawrite),
        .bank_select   (bank_select),
        .bus_dataread  (bus_dataread),
        .bus_stall     (bus_stall),
        .push          (push),
        .push_data     (push_data),
        .full          (full),
        .read_done     (read_done),
        .rd_word       (rd_word)
    );

    sdram_req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk_sys   (clk_sys),
        .reset_n   (reset_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head_data (head_data),
        .empty     (empty),
        .full      (full)
    );

    sdram_port_master u_master (
        .clk_sys    (clk_sys),
        .reset_n    (reset_n),
        .empty      (empty),
        .head_data  (head_data),
        .pop        (pop),
        .sdr_addr   (sdr_addr),
        .sdr_din    (sdr_din),
        .sdr_wr_sel (sdr_wr_sel),
        .sdr_req    (sdr_req),
        .sdr_dout   (sdr_dout),
        .sdr_rdy    (sdr_rdy),
        .read_done  (read_done),
        .rd_word    (rd_word)
    );

endmodule

//--- rtl/sdram_port_master.sv
module sdram_port_master import cpu_bus_pkg::*; (
    input  logic      clk_sys,
    input  logic      reset_n,

    input  logic      empty,
    input  req_word_t head_data,
    output logic      pop,

    output sdr_addr_t sdr_addr,
    output word_t     sdr_din,
    output byte_sel_t sdr_wr_sel,
    output logic      sdr_req,
    input  word_t     sdr_dout,
    input  logic      sdr_rdy,

    output logic      read_done,
    output word_t     rd_word
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_t;

    state_t state;
    logic   odd_q;  // Request came from an odd CPU address

    assign pop     = (state == ST_IDLE) && !empty;
    assign sdr_req = state == ST_REQ;

    // ========================================================================
    // Control
    // ========================================================================
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            state     <= ST_IDLE;
            read_done <= 1'b0;
        end else begin
            read_done <= 1'b0;
            case (state)
                ST_IDLE: if (!empty) state <= ST_REQ;
                ST_REQ:  state <= ST_WAIT;
                ST_WAIT: begin
                    if (sdr_rdy) begin
                        state     <= ST_IDLE;
                        read_done <= sdr_wr_sel == 2'b00;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ========================================================================
    // Request and read data
    // ========================================================================
    always_ff @(posedge clk_sys) begin
        if (pop) begin
            sdr_addr   <= head_data[REQ_ADDR_LSB +: $bits(sdr_addr_t)];
            sdr_din    <= head_data[REQ_DATA_LSB +: $bits(word_t)];
            sdr_wr_sel <= head_data[REQ_SEL_LSB +: $bits(byte_sel_t)];
            odd_q      <= head_data[REQ_ODD_BIT];
        end
        if (state == ST_WAIT && sdr_rdy && sdr_wr_sel == 2'b00) begin
            // Odd read returns the high byte in the low lane
            rd_word <= odd_q ? {8'h00, sdr_dout[15:8]} : sdr_dout;
        end
    end

    // Only one request in flight, so ready never comes unasked
    a_rdy_in_wait: assert property (@(posedge clk_sys) disable iff (!reset_n)
        sdr_rdy |-> state == ST_WAIT);

endmodule

//--- rtl/sdram_req_queue.sv
module sdram_req_queue import cpu_bus_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic      clk_sys,
    input  logic      reset_n,

    input  logic      push,
    input  req_word_t push_data,
    input  logic      pop,

    output req_word_t head_data,
    output logic      empty,
    output logic      full
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    req_word_t        mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W:0]   count;

    // Request storage
    always_ff @(posedge clk_sys) begin
        if (push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at the power-of-two depth
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_data = mem[rd_ptr];
    assign empty     = count == '0;
    assign full      = count == (PTR_W + 1)'(QUEUE_DEPTH);

    // ========================================================================
    // Handshake checks
    // ========================================================================
    a_no_push_full: assert property (@(posedge clk_sys) disable iff (!reset_n)
        full |-> !push);

    a_no_pop_empty: assert property (@(posedge clk_sys) disable iff (!reset_n)
        empty |-> !pop);

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
    --top-module tb_cpu_sdram_bridge -f sim.f -o tb_sim

output=$(./obj_dir/tb_sim 2>&1) || true
echo "$output"

if ! grep -q "ALL TESTS PASSED" <<< "$output"; then
    exit 1
fi

//--- sim.f
rtl/cpu_bus_pkg.sv
rtl/cpu_bus_capture.sv
rtl/sdram_req_queue.sv
rtl/sdram_port_master.sv
rtl/cpu_sdram_bridge.sv
dv/sdram_model.sv
dv/tb_cpu_sdram_bridge.sv
